//--- hw/axis_mux_params.svh
// widths and port count for the four-input stream multiplexer
// the port count cannot change without editing the top-level port list
// keep width must stay at one bit per data byte
`ifndef AXIS_MUX_PARAMS_SVH
`define AXIS_MUX_PARAMS_SVH

// tdata width in bits
`define AXM_DATA_WIDTH 64

// one tkeep bit per byte of tdata
`define AXM_KEEP_WIDTH 8

// number of stream inputs
`define AXM_PORTS 4

// statistics counters wrap at this width
`define AXM_COUNT_WIDTH 16

`endif

//--- hw/axis_mux_pkg.sv
// scalar types shared by the multiplexer RTL and its testbench
// widths follow the macros in the params header
`include "axis_mux_params.svh"

package axis_mux_pkg;

    // index of one stream input
    typedef logic [$clog2(`AXM_PORTS)-1:0] port_sel_t;

    // wrapping frame counter
    typedef logic [`AXM_COUNT_WIDTH-1:0] count_t;

    // payload of one beat
    typedef logic [`AXM_DATA_WIDTH-1:0] data_t;

    // byte enables of one beat
    typedef logic [`AXM_KEEP_WIDTH-1:0] keep_t;

endpackage

//--- hw/axis_mux_top.sv
// four-input AXI4-Stream packet multiplexer, 64-bit datapath
// select is user driven and only takes effect between frames
// frames never interleave, the output beat is always registered
`timescale 1ns/10ps

module axis_mux_top (
    input  logic                    clk,
    input  logic                    rst,
    input  axis_mux_pkg::port_sel_t select,
    input  axis_mux_pkg::data_t     in0_tdata,
    input  axis_mux_pkg::keep_t     in0_tkeep,
    input  logic                    in0_tvalid,
    output logic                    in0_tready,
    input  logic                    in0_tlast,
    input  logic                    in0_tuser,
    input  axis_mux_pkg::data_t     in1_tdata,
    input  axis_mux_pkg::keep_t     in1_tkeep,
    input  logic                    in1_tvalid,
    output logic                    in1_tready,
    input  logic                    in1_tlast,
    input  logic                    in1_tuser,
    input  axis_mux_pkg::data_t     in2_tdata,
    input  axis_mux_pkg::keep_t     in2_tkeep,
    input  logic                    in2_tvalid,
    output logic                    in2_tready,
    input  logic                    in2_tlast,
    input  logic                    in2_tuser,
    input  axis_mux_pkg::data_t     in3_tdata,
    input  axis_mux_pkg::keep_t     in3_tkeep,
    input  logic                    in3_tvalid,
    output logic                    in3_tready,
    input  logic                    in3_tlast,
    input  logic                    in3_tuser,
    output axis_mux_pkg::data_t     out_tdata,
    output axis_mux_pkg::keep_t     out_tkeep,
    output logic                    out_tvalid,
    input  logic                    out_tready,
    output logic                    out_tlast,
    output logic                    out_tuser,
    output axis_mux_pkg::count_t    frame_count_0,
    output axis_mux_pkg::count_t    frame_count_1,
    output axis_mux_pkg::count_t    frame_count_2,
    output axis_mux_pkg::count_t    frame_count_3,
    output axis_mux_pkg::count_t    bad_frame_count
);

    axis_mux_pkg::port_sel_t sel_locked;
    axis_mux_pkg::data_t     cur_tdata;
    axis_mux_pkg::keep_t     cur_tkeep;
    logic                    cur_tvalid;
    logic                    cur_tlast;
    logic                    cur_tuser;
    logic                    beat_valid;
    logic                    ready_early;
    logic                    frame_end;

    mux_frame_ctrl i_frame_ctrl (
        .clk         (clk),
        .rst         (rst),
        .select      (select),
        .in0_tvalid  (in0_tvalid),
        .in1_tvalid  (in1_tvalid),
        .in2_tvalid  (in2_tvalid),
        .in3_tvalid  (in3_tvalid),
        .cur_tvalid  (cur_tvalid),
        .cur_tlast   (cur_tlast),
        .ready_early (ready_early),
        .in0_tready  (in0_tready),
        .in1_tready  (in1_tready),
        .in2_tready  (in2_tready),
        .in3_tready  (in3_tready),
        .sel_locked  (sel_locked),
        .beat_valid  (beat_valid),
        .frame_end   (frame_end)
    );

    mux_port_select i_port_select (
        .sel_locked (sel_locked),
        .in0_tdata  (in0_tdata),
        .in0_tkeep  (in0_tkeep),
        .in0_tvalid (in0_tvalid),
        .in0_tlast  (in0_tlast),
        .in0_tuser  (in0_tuser),
        .in1_tdata  (in1_tdata),
        .in1_tkeep  (in1_tkeep),
        .in1_tvalid (in1_tvalid),
        .in1_tlast  (in1_tlast),
        .in1_tuser  (in1_tuser),
        .in2_tdata  (in2_tdata),
        .in2_tkeep  (in2_tkeep),
        .in2_tvalid (in2_tvalid),
        .in2_tlast  (in2_tlast),
        .in2_tuser  (in2_tuser),
        .in3_tdata  (in3_tdata),
        .in3_tkeep  (in3_tkeep),
        .in3_tvalid (in3_tvalid),
        .in3_tlast  (in3_tlast),
        .in3_tuser  (in3_tuser),
        .cur_tdata  (cur_tdata),
        .cur_tkeep  (cur_tkeep),
        .cur_tvalid (cur_tvalid),
        .cur_tlast  (cur_tlast),
        .cur_tuser  (cur_tuser)
    );

    axis_skid_reg i_skid_reg (
        .clk         (clk),
        .rst         (rst),
        .beat_valid  (beat_valid),
        .cur_tdata   (cur_tdata),
        .cur_tkeep   (cur_tkeep),
        .cur_tlast   (cur_tlast),
        .cur_tuser   (cur_tuser),
        .out_tready  (out_tready),
        .ready_early (ready_early),
        .out_tdata   (out_tdata),
        .out_tkeep   (out_tkeep),
        .out_tvalid  (out_tvalid),
        .out_tlast   (out_tlast),
        .out_tuser   (out_tuser)
    );

    mux_frame_stats i_frame_stats (
        .clk             (clk),
        .rst             (rst),
        .frame_end       (frame_end),
        .sel_locked      (sel_locked),
        .cur_tuser       (cur_tuser),
        .frame_count_0   (frame_count_0),
        .frame_count_1   (frame_count_1),
        .frame_count_2   (frame_count_2),
        .frame_count_3   (frame_count_3),
        .bad_frame_count (bad_frame_count)
    );

endmodule

//--- hw/axis_skid_reg.sv
// two-entry output register with an early ready
// the upstream ready must be ready_early delayed by one cycle
// beat_valid is only honoured while that delayed ready is high
`timescale 1ns/10ps

module axis_skid_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                beat_valid,
    input  axis_mux_pkg::data_t cur_tdata,
    input  axis_mux_pkg::keep_t cur_tkeep,
    input  logic                cur_tlast,
    input  logic                cur_tuser,
    input  logic                out_tready,
    output logic                ready_early,
    output axis_mux_pkg::data_t out_tdata,
    output axis_mux_pkg::keep_t out_tkeep,
    output logic                out_tvalid,
    output logic                out_tlast,
    output logic                out_tuser
);

    // registered copy of ready_early, matches the upstream tready
    logic                ready_q;

    axis_mux_pkg::data_t temp_tdata;
    axis_mux_pkg::keep_t temp_tkeep;
    logic                temp_tlast;
    logic                temp_tuser;
    logic                temp_valid;

    logic                out_valid_next;
    logic                temp_valid_next;
    logic                load_out_from_in;
    logic                load_temp_from_in;
    logic                load_out_from_temp;

    // accept next cycle if the sink drains, or if a slot stays free
    assign ready_early = out_tready | (~temp_valid & (~out_tvalid | ~beat_valid));

    always_comb begin
        out_valid_next     = out_tvalid;
        temp_valid_next    = temp_valid;
        load_out_from_in   = 1'b0;
        load_temp_from_in  = 1'b0;
        load_out_from_temp = 1'b0;

        if (ready_q) begin
            if (out_tready | ~out_tvalid) begin
                // output slot free this cycle
                out_valid_next   = beat_valid;
                load_out_from_in = 1'b1;
            end else begin
                // sink stalled, park the beat
                temp_valid_next   = beat_valid;
                load_temp_from_in = 1'b1;
            end
        end else if (out_tready) begin
            out_valid_next     = temp_valid;
            temp_valid_next    = 1'b0;
            load_out_from_temp = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ready_q    <= 1'b0;
            out_tvalid <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            ready_q    <= ready_early;
            out_tvalid <= out_valid_next;
            temp_valid <= temp_valid_next;
        end
    end

    // payload only, qualified by the valid flags above
    always_ff @(posedge clk) begin
        if (load_out_from_in) begin
            out_tdata <= cur_tdata;
            out_tkeep <= cur_tkeep;
            out_tlast <= cur_tlast;
            out_tuser <= cur_tuser;
        end else if (load_out_from_temp) begin
            out_tdata <= temp_tdata;
            out_tkeep <= temp_tkeep;
            out_tlast <= temp_tlast;
            out_tuser <= temp_tuser;
        end
        if (load_temp_from_in) begin
            temp_tdata <= cur_tdata;
            temp_tkeep <= cur_tkeep;
            temp_tlast <= cur_tlast;
            temp_tuser <= cur_tuser;
        end
    end

endmodule

//--- hw/mux_frame_ctrl.sv
// frame control for the stream multiplexer
// select is sampled only while no frame is open, then held until tlast
// tready is registered, so it lags ready_early by one cycle
`timescale 1ns/10ps
`include "axis_mux_params.svh"

module mux_frame_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  axis_mux_pkg::port_sel_t select,
    input  logic                    in0_tvalid,
    input  logic                    in1_tvalid,
    input  logic                    in2_tvalid,
    input  logic                    in3_tvalid,
    input  logic                    cur_tvalid,
    input  logic                    cur_tlast,
    input  logic                    ready_early,
    output logic                    in0_tready,
    output logic                    in1_tready,
    output logic                    in2_tready,
    output logic                    in3_tready,
    output axis_mux_pkg::port_sel_t sel_locked,
    output logic                    beat_valid,
    output logic                    frame_end
);

    logic                    frame_open;
    logic                    frame_next;
    axis_mux_pkg::port_sel_t sel_next;
    logic [`AXM_PORTS-1:0]   valid_vec;
    logic [`AXM_PORTS-1:0]   ready_q;
    logic [`AXM_PORTS-1:0]   ready_next;
    logic                    start_valid;
    logic                    cur_ready;

    assign valid_vec = {in3_tvalid, in2_tvalid, in1_tvalid, in0_tvalid};

    // live select decides which input may open the next frame
    assign start_valid = valid_vec[select];

    // ready currently shown to the locked input
    assign cur_ready = ready_q[sel_locked];

    assign beat_valid = cur_tvalid & cur_ready & frame_open;
    assign frame_end  = beat_valid & cur_tlast;

    always_comb begin
        sel_next   = sel_locked;
        frame_next = frame_open;

        if (frame_open) begin
            // the tlast transfer closes the frame
            if (beat_valid) begin
                frame_next = ~cur_tlast;
            end
        end else if (start_valid) begin
            frame_next = 1'b1;
            sel_next   = select;
        end

        // only the port owning the next-cycle frame gets ready
        ready_next           = '0;
        ready_next[sel_next] = ready_early & frame_next;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_open <= 1'b0;
            sel_locked <= '0;
            ready_q    <= '0;
        end else begin
            frame_open <= frame_next;
            sel_locked <= sel_next;
            ready_q    <= ready_next;
        end
    end

    assign in0_tready = ready_q[0];
    assign in1_tready = ready_q[1];
    assign in2_tready = ready_q[2];
    assign in3_tready = ready_q[3];

endmodule

//--- hw/mux_frame_stats.sv
// per-input frame counters plus a count of frames ending with tuser set
// all counters wrap silently at their width
// counts are taken on the edge that accepts the tlast beat
`timescale 1ns/10ps
`include "axis_mux_params.svh"

module mux_frame_stats (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_end,
    input  axis_mux_pkg::port_sel_t sel_locked,
    input  logic                    cur_tuser,
    output axis_mux_pkg::count_t    frame_count_0,
    output axis_mux_pkg::count_t    frame_count_1,
    output axis_mux_pkg::count_t    frame_count_2,
    output axis_mux_pkg::count_t    frame_count_3,
    output axis_mux_pkg::count_t    bad_frame_count
);

    axis_mux_pkg::count_t frame_cnt [`AXM_PORTS];
    axis_mux_pkg::count_t bad_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_cnt <= '{default: '0};
            bad_cnt   <= '0;
        end else if (frame_end) begin
            frame_cnt[sel_locked] <= frame_cnt[sel_locked] + 1'b1;
            // tuser on the last beat marks the frame as bad
            if (cur_tuser) begin
                bad_cnt <= bad_cnt + 1'b1;
            end
        end
    end

    assign frame_count_0   = frame_cnt[0];
    assign frame_count_1   = frame_cnt[1];
    assign frame_count_2   = frame_cnt[2];
    assign frame_count_3   = frame_cnt[3];
    assign bad_frame_count = bad_cnt;

endmodule

//--- hw/mux_port_select.sv
// steers the beat fields of the locked input onto one internal stream
// purely combinational, the lock itself lives in the frame control
`timescale 1ns/10ps

module mux_port_select (
    input  axis_mux_pkg::port_sel_t sel_locked,
    input  axis_mux_pkg::data_t     in0_tdata,
    input  axis_mux_pkg::keep_t     in0_tkeep,
    input  logic                    in0_tvalid,
    input  logic                    in0_tlast,
    input  logic                    in0_tuser,
    input  axis_mux_pkg::data_t     in1_tdata,
    input  axis_mux_pkg::keep_t     in1_tkeep,
    input  logic                    in1_tvalid,
    input  logic                    in1_tlast,
    input  logic                    in1_tuser,
    input  axis_mux_pkg::data_t     in2_tdata,
    input  axis_mux_pkg::keep_t     in2_tkeep,
    input  logic                    in2_tvalid,
    input  logic                    in2_tlast,
    input  logic                    in2_tuser,
    input  axis_mux_pkg::data_t     in3_tdata,
    input  axis_mux_pkg::keep_t     in3_tkeep,
    input  logic                    in3_tvalid,
    input  logic                    in3_tlast,
    input  logic                    in3_tuser,
    output axis_mux_pkg::data_t     cur_tdata,
    output axis_mux_pkg::keep_t     cur_tkeep,
    output logic                    cur_tvalid,
    output logic                    cur_tlast,
    output logic                    cur_tuser
);

    always_comb begin
        case (sel_locked)
            2'd0: begin
                cur_tdata  = in0_tdata;
                cur_tkeep  = in0_tkeep;
                cur_tvalid = in0_tvalid;
                cur_tlast  = in0_tlast;
                cur_tuser  = in0_tuser;
            end
            2'd1: begin
                cur_tdata  = in1_tdata;
                cur_tkeep  = in1_tkeep;
                cur_tvalid = in1_tvalid;
                cur_tlast  = in1_tlast;
                cur_tuser  = in1_tuser;
            end
            2'd2: begin
                cur_tdata  = in2_tdata;
                cur_tkeep  = in2_tkeep;
                cur_tvalid = in2_tvalid;
                cur_tlast  = in2_tlast;
                cur_tuser  = in2_tuser;
            end
            default: begin
                cur_tdata  = in3_tdata;
                cur_tkeep  = in3_tkeep;
                cur_tvalid = in3_tvalid;
                cur_tlast  = in3_tlast;
                cur_tuser  = in3_tuser;
            end
        endcase
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the stream multiplexer testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_axis_mux -f src.f -o sim_axis_mux > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_axis_mux > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

//--- src.f
+incdir+hw
hw/axis_mux_pkg.sv
hw/mux_frame_ctrl.sv
hw/mux_port_select.sv
hw/axis_skid_reg.sv
hw/mux_frame_stats.sv
hw/axis_mux_top.sv
verif/tb_clk_gen.sv
verif/tb_axis_mux.sv

//--- verif/tb_axis_mux.sv
// directed testbench for the four-input stream multiplexer
// sources and sink are driven 1 ns after the rising edge
// handshakes and output beats are sampled on the falling edge
// expected beats follow a fixed pattern built from port, frame id and beat index
`timescale 1ns/10ps

module tb_axis_mux;

    // about 1000 cycles of traffic in total, the limit leaves a wide margin
    localparam int MAX_CYCLES = 20000;

    logic                    clk;
    logic                    rst;
    axis_mux_pkg::port_sel_t select;
    axis_mux_pkg::data_t     src_data [4];
    axis_mux_pkg::keep_t     src_keep [4];
    logic [3:0]              src_valid;
    logic [3:0]              src_last;
    logic [3:0]              src_user;
    wire  [3:0]              src_ready;
    axis_mux_pkg::data_t     out_tdata;
    axis_mux_pkg::keep_t     out_tkeep;
    logic                    out_tvalid;
    logic                    out_tready;
    logic                    out_tlast;
    logic                    out_tuser;
    axis_mux_pkg::count_t    frame_count [4];
    axis_mux_pkg::count_t    bad_frame_count;

    axis_mux_pkg::data_t     exp_data [$];
    axis_mux_pkg::keep_t     exp_keep [$];
    logic                    exp_last [$];
    logic                    exp_user [$];
    axis_mux_pkg::data_t     got_data [$];
    axis_mux_pkg::keep_t     got_keep [$];
    logic                    got_last [$];
    logic                    got_user [$];
    axis_mux_pkg::count_t    exp_frames [4];
    axis_mux_pkg::count_t    exp_bad;

    string                   test_name;
    logic [3:0]              frame_sent;
    logic                    bp_running;
    int                      next_fid;
    int                      cycle_count;
    int                      checks;
    int                      errors;

    tb_clk_gen i_tb_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    axis_mux_top i_axis_mux_top (
        .clk             (clk),
        .rst             (rst),
        .select          (select),
        .in0_tdata       (src_data[0]),
        .in0_tkeep       (src_keep[0]),
        .in0_tvalid      (src_valid[0]),
        .in0_tready      (src_ready[0]),
        .in0_tlast       (src_last[0]),
        .in0_tuser       (src_user[0]),
        .in1_tdata       (src_data[1]),
        .in1_tkeep       (src_keep[1]),
        .in1_tvalid      (src_valid[1]),
        .in1_tready      (src_ready[1]),
        .in1_tlast       (src_last[1]),
        .in1_tuser       (src_user[1]),
        .in2_tdata       (src_data[2]),
        .in2_tkeep       (src_keep[2]),
        .in2_tvalid      (src_valid[2]),
        .in2_tready      (src_ready[2]),
        .in2_tlast       (src_last[2]),
        .in2_tuser       (src_user[2]),
        .in3_tdata       (src_data[3]),
        .in3_tkeep       (src_keep[3]),
        .in3_tvalid      (src_valid[3]),
        .in3_tready      (src_ready[3]),
        .in3_tlast       (src_last[3]),
        .in3_tuser       (src_user[3]),
        .out_tdata       (out_tdata),
        .out_tkeep       (out_tkeep),
        .out_tvalid      (out_tvalid),
        .out_tready      (out_tready),
        .out_tlast       (out_tlast),
        .out_tuser       (out_tuser),
        .frame_count_0   (frame_count[0]),
        .frame_count_1   (frame_count[1]),
        .frame_count_2   (frame_count[2]),
        .frame_count_3   (frame_count[3]),
        .bad_frame_count (bad_frame_count)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // output beats are stable at the falling edge and transfer on the next rising edge
    always @(negedge clk) begin
        if (!rst && out_tvalid && out_tready) begin
            got_data.push_back(out_tdata);
            got_keep.push_back(out_tkeep);
            got_last.push_back(out_tlast);
            got_user.push_back(out_tuser);
        end
    end

    function automatic axis_mux_pkg::port_sel_t to_port(input int i);
        return axis_mux_pkg::port_sel_t'(i);
    endfunction

    function automatic axis_mux_pkg::data_t beat_data(input axis_mux_pkg::port_sel_t p,
                                                      input int fid, input int b);
        return {6'd0, p, 24'(fid), 16'(b), 16'hc3a5};
    endfunction

    // only the last beat of a frame has a partial keep
    function automatic axis_mux_pkg::keep_t beat_keep(input int fid, input int b, input int n);
        if (b == n - 1) begin
            return axis_mux_pkg::keep_t'(8'hff >> (fid % 8));
        end
        return 8'hff;
    endfunction

    task automatic check_data(input string what, input axis_mux_pkg::data_t exp,
                              input axis_mux_pkg::data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_keep(input string what, input axis_mux_pkg::keep_t exp,
                              input axis_mux_pkg::keep_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_count(input string what, input axis_mux_pkg::count_t exp,
                               input axis_mux_pkg::count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the edge that takes the beat
    task automatic send_beat(input axis_mux_pkg::port_sel_t p, input axis_mux_pkg::data_t d,
                             input axis_mux_pkg::keep_t k, input logic l, input logic u);
        src_data[p]  = d;
        src_keep[p]  = k;
        src_last[p]  = l;
        src_user[p]  = u;
        src_valid[p] = 1'b1;
        @(negedge clk);
        while (!src_ready[p]) @(negedge clk);
        @(posedge clk);
        #1;
        src_valid[p] = 1'b0;
    endtask

    task automatic send_frame(input axis_mux_pkg::port_sel_t p, input int fid, input int n,
                              input logic last_user);
        frame_sent[p] = 1'b0;
        for (int b = 0; b < n; b++) begin
            send_beat(p, beat_data(p, fid, b), beat_keep(fid, b, n), b == n - 1,
                      (b == n - 1) & last_user);
        end
        frame_sent[p] = 1'b1;
    endtask

    task automatic expect_frame(input axis_mux_pkg::port_sel_t p, input int fid, input int n,
                                input logic last_user);
        for (int b = 0; b < n; b++) begin
            exp_data.push_back(beat_data(p, fid, b));
            exp_keep.push_back(beat_keep(fid, b, n));
            exp_last.push_back(b == n - 1);
            exp_user.push_back((b == n - 1) & last_user);
        end
        exp_frames[p]++;
        if (last_user) begin
            exp_bad++;
        end
    endtask

    // waits for the expected beats, then a few idle cycles to catch extra ones
    task automatic compare_beats();
        int n;
        while (got_data.size() < exp_data.size()) @(negedge clk);
        repeat (8) @(negedge clk);
        if (got_data.size() != exp_data.size()) begin
            errors++;
            $display("CHECK FAILED %s beat count: expected %0d, actual %0d", test_name,
                     exp_data.size(), got_data.size());
        end
        n = exp_data.size();
        for (int i = 0; i < n; i++) begin
            check_data($sformatf("tdata[%0d]", i), exp_data[i], got_data[i]);
            check_keep($sformatf("tkeep[%0d]", i), exp_keep[i], got_keep[i]);
            check_bit($sformatf("tlast[%0d]", i), exp_last[i], got_last[i]);
            check_bit($sformatf("tuser[%0d]", i), exp_user[i], got_user[i]);
        end
        exp_data.delete();
        exp_keep.delete();
        exp_last.delete();
        exp_user.delete();
        got_data.delete();
        got_keep.delete();
        got_last.delete();
        got_user.delete();
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_state();
        test_name = "reset_state";
        for (int i = 0; i < 4; i++) begin
            check_bit($sformatf("in%0d_tready", i), 1'b0, src_ready[i]);
            check_count($sformatf("frame_count_%0d", i), '0, frame_count[i]);
        end
        check_bit("out_tvalid", 1'b0, out_tvalid);
        check_count("bad_frame_count", '0, bad_frame_count);
    endtask

    task automatic test_pass_through();
        test_name = "pass_through";
        for (int i = 0; i < 4; i++) begin
            select = to_port(i);
            expect_frame(to_port(i), next_fid, 3, 1'b0);
            send_frame(to_port(i), next_fid, 3, 1'b0);
            next_fid++;
        end
        compare_beats();
    endtask

    // select moves to port 2 while the port 1 frame is still open
    task automatic test_select_lock();
        test_name = "select_lock";
        select = 2'd1;
        expect_frame(2'd1, next_fid, 4, 1'b0);
        expect_frame(2'd2, next_fid + 1, 3, 1'b0);
        fork
            send_frame(2'd1, next_fid, 4, 1'b0);
            send_frame(2'd2, next_fid + 1, 3, 1'b0);
            begin
                repeat (2) @(posedge clk);
                #1;
                select = 2'd2;
            end
        join
        next_fid += 2;
        compare_beats();
    endtask

    task automatic test_unselected_stall();
        axis_mux_pkg::port_sel_t p;
        test_name = "unselected_stall";
        select = 2'd0;
        frame_sent = '0;
        for (int i = 0; i < 4; i++) begin
            expect_frame(to_port(i), next_fid + i, 2 + i, 1'b0);
        end
        fork
            send_frame(2'd0, next_fid, 2, 1'b0);
            send_frame(2'd1, next_fid + 1, 3, 1'b0);
            send_frame(2'd2, next_fid + 2, 4, 1'b0);
            send_frame(2'd3, next_fid + 3, 5, 1'b0);
            for (int i = 0; i < 4; i++) begin
                p = to_port(i);
                while (!frame_sent[p]) begin
                    @(negedge clk);
                    for (int q = 0; q < 4; q++) begin
                        if (q != i) begin
                            check_bit($sformatf("in%0d_tready", q), 1'b0, src_ready[q]);
                        end
                    end
                end
                if (i < 3) begin
                    @(posedge clk);
                    #1;
                    select = to_port(i + 1);
                end
            end
        join
        next_fid += 4;
        compare_beats();
    endtask

    task automatic test_back_pressure();
        axis_mux_pkg::port_sel_t p;
        int                      n;
        test_name = "back_pressure";
        bp_running = 1'b1;
        fork
            begin
                for (int f = 0; f < 50; f++) begin
                    p = to_port($urandom_range(0, 3));
                    n = $urandom_range(1, 8);
                    select = p;
                    expect_frame(p, next_fid, n, 1'b0);
                    send_frame(p, next_fid, n, 1'b0);
                    next_fid++;
                end
                bp_running = 1'b0;
            end
            begin
                while (bp_running) begin
                    @(posedge clk);
                    #1;
                    out_tready = 1'($urandom_range(0, 1));
                end
                out_tready = 1'b1;
            end
        join
        compare_beats();
    endtask

    task automatic test_counters();
        test_name = "counters";
        for (int i = 0; i < 4; i++) begin
            select = to_port(i);
            expect_frame(to_port(i), next_fid, 2, 1'b1);
            send_frame(to_port(i), next_fid, 2, 1'b1);
            next_fid++;
        end
        compare_beats();
        for (int i = 0; i < 4; i++) begin
            check_count($sformatf("frame_count_%0d", i), exp_frames[i], frame_count[i]);
        end
        check_count("bad_frame_count", exp_bad, bad_frame_count);
    endtask

    initial begin
        select     = '0;
        src_valid  = '0;
        src_last   = '0;
        src_user   = '0;
        out_tready = 1'b1;
        for (int i = 0; i < 4; i++) begin
            src_data[i]   = '0;
            src_keep[i]   = '0;
            exp_frames[i] = '0;
        end
        exp_bad     = '0;
        frame_sent  = '0;
        bp_running  = 1'b0;
        next_fid    = 1;
        cycle_count = 0;
        checks      = 0;
        errors      = 0;
        void'($urandom(79415));

        wait (rst === 1'b0);
        @(posedge clk);
        #1;

        test_reset_state();
        test_pass_through();
        test_select_lock();
        test_unselected_stall();
        test_back_pressure();
        test_counters();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_clk_gen.sv
// clock and reset source for the multiplexer testbench
// 10 ns period, reset held high over the first 4 rising edges
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release 1 ns after the fourth edge, in step with the stimulus
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule
